//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= rv_tb
FILELIST  ?= rv_core.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q -F '** PASS **' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- rv_core.f
rv_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_result.sv
rv_core.sv
rv_tb_clk.sv
rv_tb.sv

//--- rv_core.sv
// multi-cycle RV64I core top, sequences fetch, execute, memory and write-back over Wishbone
`timescale 1ns/1ns

module rv_core (
	input  logic              clk,
	input  logic              rst,
	output logic              wb_cyc,
	output logic              wb_stb,
	output logic              wb_we,
	output rv_pkg::xlen_t     wb_adr,
	output rv_pkg::xlen_t     wb_dat_w,
	output rv_pkg::byte_sel_t wb_sel,
	input  rv_pkg::xlen_t     wb_dat_r,
	input  logic              wb_ack
);
	import rv_pkg::*;

	typedef enum logic [1:0] {S_FETCH, S_EXECUTE, S_MEMORY, S_WRITEBACK} state_t;

	state_t     state;
	xlen_t      pc;
	inst_t      ir;
	xlen_t      load_data;
	reg_addr_t  rs1_addr;
	reg_addr_t  rs2_addr;
	reg_addr_t  rd_addr;
	logic       rd_w_ena;
	logic       rf_w_ena;
	alu_op_t    alu_op;
	logic       alu_op1_src;
	logic [1:0] alu_op2_src;
	xlen_t      imm;
	logic       branch;
	logic       jump;
	logic       jump_reg;
	logic       mem_r_ena;
	logic       mem_w_ena;
	logic       mem_ext_un;
	logic [1:0] mem_size;
	xlen_t      rs1_data;
	xlen_t      rs2_data;
	xlen_t      alu_result;
	xlen_t      next_pc;
	xlen_t      store_data;
	byte_sel_t  store_sel;
	xlen_t      rd_data;

	rv_decode u_decode (
		.inst(ir), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
		.rd_w_ena(rd_w_ena), .alu_op(alu_op), .alu_op1_src(alu_op1_src),
		.alu_op2_src(alu_op2_src), .imm(imm), .branch(branch), .jump(jump),
		.jump_reg(jump_reg), .mem_r_ena(mem_r_ena), .mem_w_ena(mem_w_ena),
		.mem_ext_un(mem_ext_un), .mem_size(mem_size)
	);

	// register write only commits in write-back
	assign rf_w_ena = (state == S_WRITEBACK) && rd_w_ena;

	rv_regfile u_regfile (
		.clk(clk), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
		.rd_w_ena(rf_w_ena), .rd_data(rd_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	rv_execute u_execute (
		.pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .alu_op(alu_op),
		.alu_op1_src(alu_op1_src), .alu_op2_src(alu_op2_src), .branch(branch),
		.jump(jump), .jump_reg(jump_reg), .alu_result(alu_result), .next_pc(next_pc),
		.branch_taken()
	);

	rv_result u_result (
		.addr(alu_result), .rs2_data(rs2_data), .mem_rdata(load_data),
		.alu_result(alu_result), .mem_size(mem_size), .mem_ext_un(mem_ext_un),
		.mem_r_ena(mem_r_ena), .store_data(store_data), .store_sel(store_sel),
		.rd_data(rd_data)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= S_FETCH;
			pc     <= RESET_PC;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we  <= 1'b0;
		end else begin
			case (state)
				S_FETCH: begin
					if (!wb_cyc) begin
						// whole doubleword holding the pc
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
						wb_we  <= 1'b0;
						wb_adr <= {pc[63:3], 3'b000};
						wb_sel <= '1;
					end else if (wb_ack) begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						ir     <= pc[2] ? wb_dat_r[63:32] : wb_dat_r[31:0];
						state  <= S_EXECUTE;
					end
				end
				S_EXECUTE: begin
					if (mem_r_ena || mem_w_ena) begin
						wb_cyc   <= 1'b1;
						wb_stb   <= 1'b1;
						wb_we    <= mem_w_ena;
						wb_adr   <= {alu_result[63:3], 3'b000};
						wb_dat_w <= store_data;
						wb_sel   <= store_sel;
						state    <= S_MEMORY;
					end else begin
						state <= S_WRITEBACK;
					end
				end
				S_MEMORY: begin
					if (wb_ack) begin
						wb_cyc    <= 1'b0;
						wb_stb    <= 1'b0;
						wb_we     <= 1'b0;
						load_data <= wb_dat_r;
						state     <= S_WRITEBACK;
					end
				end
				default: begin
					pc    <= next_pc;
					state <= S_FETCH;
				end
			endcase
		end
	end

endmodule

//--- rv_decode.sv
// combinational RV64I decoder, turns one instruction word into core controls
`timescale 1ns/1ns

module rv_decode (
	input  rv_pkg::inst_t     inst,
	output rv_pkg::reg_addr_t rs1_addr,
	output rv_pkg::reg_addr_t rs2_addr,
	output rv_pkg::reg_addr_t rd_addr,
	output logic              rd_w_ena,
	output rv_pkg::alu_op_t   alu_op,
	output logic              alu_op1_src,
	output logic [1:0]        alu_op2_src,
	output rv_pkg::xlen_t     imm,
	output logic              branch,
	output logic              jump,
	output logic              jump_reg,
	output logic              mem_r_ena,
	output logic              mem_w_ena,
	output logic              mem_ext_un,
	output logic [1:0]        mem_size
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       f7_ok;
	xlen_t      imm_i;
	xlen_t      imm_s;
	xlen_t      imm_b;
	xlen_t      imm_u;
	xlen_t      imm_j;

	assign opcode   = inst[6:0];
	assign funct3   = inst[14:12];
	assign rd_addr  = inst[11:7];
	assign rs1_addr = inst[19:15];
	assign rs2_addr = inst[24:20];
	assign mem_size = funct3[1:0];

	// funct7 may only carry bit 30 for register ops
	assign f7_ok = (inst[31:25] & 7'b1011111) == 7'b0;

	assign imm_i = {{52{inst[31]}}, inst[31:20]};
	assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
	assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		// anything not matched below runs as a nop
		rd_w_ena    = 1'b0;
		alu_op      = ALU_ZERO;
		alu_op1_src = OP1_REG;
		alu_op2_src = OP2_REG;
		imm         = '0;
		branch      = 1'b0;
		jump        = 1'b0;
		jump_reg    = 1'b0;
		mem_r_ena   = 1'b0;
		mem_w_ena   = 1'b0;
		mem_ext_un  = 1'b0;
		case (opcode)
			OPC_OP: begin
				if (f7_ok) begin
					rd_w_ena = 1'b1;
					case (funct3)
						F3_ADD_SUB: alu_op = inst[30] ? ALU_SUB : ALU_ADD;
						F3_SLL:     alu_op = ALU_SLL;
						F3_SLT:     alu_op = ALU_SLT;
						F3_SLTU:    alu_op = ALU_SLTU;
						F3_XOR:     alu_op = ALU_XOR;
						F3_SR:      alu_op = inst[30] ? ALU_SRA : ALU_SRL;
						F3_OR:      alu_op = ALU_OR;
						F3_AND:     alu_op = ALU_AND;
					endcase
				end
			end
			OPC_OP32: begin
				if (f7_ok) begin
					rd_w_ena = 1'b1;
					case (funct3)
						F3_ADD_SUB: alu_op = inst[30] ? ALU_SUBW : ALU_ADDW;
						F3_SLL:     alu_op = ALU_SLLW;
						F3_SR:      alu_op = inst[30] ? ALU_SRAW : ALU_SRLW;
						default:    rd_w_ena = 1'b0;
					endcase
				end
			end
			OPC_OP_IMM: begin
				// shamt sits in imm_i[5:0], bit 30 picks the arithmetic shift
				rd_w_ena    = 1'b1;
				alu_op2_src = OP2_IMM;
				imm         = imm_i;
				case (funct3)
					F3_ADD_SUB: alu_op = ALU_ADD;
					F3_SLL:     alu_op = ALU_SLL;
					F3_SLT:     alu_op = ALU_SLT;
					F3_SLTU:    alu_op = ALU_SLTU;
					F3_XOR:     alu_op = ALU_XOR;
					F3_SR:      alu_op = inst[30] ? ALU_SRA : ALU_SRL;
					F3_OR:      alu_op = ALU_OR;
					F3_AND:     alu_op = ALU_AND;
				endcase
			end
			OPC_OP_IMM32: begin
				rd_w_ena    = 1'b1;
				alu_op2_src = OP2_IMM;
				imm         = imm_i;
				case (funct3)
					F3_ADD_SUB: alu_op = ALU_ADDW;
					F3_SLL:     alu_op = ALU_SLLW;
					F3_SR:      alu_op = inst[30] ? ALU_SRAW : ALU_SRLW;
					default:    rd_w_ena = 1'b0;
				endcase
			end
			OPC_LUI: begin
				rd_w_ena    = 1'b1;
				alu_op2_src = OP2_IMM;
				imm         = imm_u;
				alu_op      = ALU_LUI;
			end
			OPC_AUIPC: begin
				rd_w_ena    = 1'b1;
				alu_op1_src = OP1_PC;
				alu_op2_src = OP2_IMM;
				imm         = imm_u;
				alu_op      = ALU_ADD;
			end
			OPC_JAL: begin
				// link value pc + 4 comes out of the alu
				rd_w_ena    = 1'b1;
				jump        = 1'b1;
				alu_op1_src = OP1_PC;
				alu_op2_src = OP2_4;
				imm         = imm_j;
				alu_op      = ALU_ADD;
			end
			OPC_JALR: begin
				rd_w_ena    = 1'b1;
				jump        = 1'b1;
				jump_reg    = 1'b1;
				alu_op1_src = OP1_PC;
				alu_op2_src = OP2_4;
				imm         = imm_i;
				alu_op      = ALU_ADD;
			end
			OPC_BRANCH: begin
				imm    = imm_b;
				branch = 1'b1;
				case (funct3)
					F3_BEQ:  alu_op = ALU_BEQ;
					F3_BNE:  alu_op = ALU_BNE;
					F3_BLT:  alu_op = ALU_BLT;
					F3_BGE:  alu_op = ALU_BGE;
					F3_BLTU: alu_op = ALU_BLTU;
					F3_BGEU: alu_op = ALU_BGEU;
					default: branch = 1'b0;
				endcase
			end
			OPC_LOAD: begin
				alu_op2_src = OP2_IMM;
				imm         = imm_i;
				alu_op      = ALU_ADD;
				case (funct3)
					F3_B, F3_H, F3_W, F3_D, F3_BU, F3_HU, F3_WU: begin
						rd_w_ena   = 1'b1;
						mem_r_ena  = 1'b1;
						mem_ext_un = funct3[2];
					end
					default: mem_r_ena = 1'b0;
				endcase
			end
			OPC_STORE: begin
				alu_op2_src = OP2_IMM;
				imm         = imm_s;
				alu_op      = ALU_ADD;
				case (funct3)
					F3_B, F3_H, F3_W, F3_D: mem_w_ena = 1'b1;
					default:                mem_w_ena = 1'b0;
				endcase
			end
			default: begin
				rd_w_ena = 1'b0;
			end
		endcase
	end

endmodule

//--- rv_execute.sv
// ALU, branch compare and next-PC logic for the multi-cycle core
`timescale 1ns/1ns

module rv_execute (
	input  rv_pkg::xlen_t   pc,
	input  rv_pkg::xlen_t   rs1_data,
	input  rv_pkg::xlen_t   rs2_data,
	input  rv_pkg::xlen_t   imm,
	input  rv_pkg::alu_op_t alu_op,
	input  logic            alu_op1_src,
	input  logic [1:0]      alu_op2_src,
	input  logic            branch,
	input  logic            jump,
	input  logic            jump_reg,
	output rv_pkg::xlen_t   alu_result,
	output rv_pkg::xlen_t   next_pc,
	output logic            branch_taken
);
	import rv_pkg::*;

	xlen_t op1;
	xlen_t op2;
	logic  cond;

	// word results are sign extended from bit 31
	function automatic xlen_t sext32(input logic [31:0] w);
		sext32 = {{32{w[31]}}, w};
	endfunction

	assign op1 = (alu_op1_src == OP1_PC) ? pc : rs1_data;

	always_comb begin
		case (alu_op2_src)
			OP2_IMM: op2 = imm;
			OP2_4:   op2 = 64'd4;
			default: op2 = rs2_data;
		endcase
	end

	always_comb begin
		alu_result = '0;
		cond       = 1'b0;
		case (alu_op)
			ALU_ADD:  alu_result = op1 + op2;
			ALU_SUB:  alu_result = op1 - op2;
			ALU_SLL:  alu_result = op1 << op2[5:0];
			ALU_SLT:  alu_result = {63'b0, $signed(op1) < $signed(op2)};
			ALU_SLTU: alu_result = {63'b0, op1 < op2};
			ALU_XOR:  alu_result = op1 ^ op2;
			ALU_SRL:  alu_result = op1 >> op2[5:0];
			ALU_SRA:  alu_result = $signed(op1) >>> op2[5:0];
			ALU_OR:   alu_result = op1 | op2;
			ALU_AND:  alu_result = op1 & op2;
			ALU_LUI:  alu_result = op2;
			ALU_ADDW: alu_result = sext32(op1[31:0] + op2[31:0]);
			ALU_SUBW: alu_result = sext32(op1[31:0] - op2[31:0]);
			ALU_SLLW: alu_result = sext32(op1[31:0] << op2[4:0]);
			ALU_SRLW: alu_result = sext32(op1[31:0] >> op2[4:0]);
			ALU_SRAW: alu_result = sext32($signed(op1[31:0]) >>> op2[4:0]);
			ALU_BEQ:  cond = op1 == op2;
			ALU_BNE:  cond = op1 != op2;
			ALU_BLT:  cond = $signed(op1) < $signed(op2);
			ALU_BGE:  cond = $signed(op1) >= $signed(op2);
			ALU_BLTU: cond = op1 < op2;
			ALU_BGEU: cond = op1 >= op2;
			default:  alu_result = '0;
		endcase
	end

	assign branch_taken = branch & cond;

	always_comb begin
		if (jump_reg) begin
			next_pc = (rs1_data + imm) & ~64'd1;
		end else if (jump || branch_taken) begin
			next_pc = pc + imm;
		end else begin
			next_pc = pc + 64'd4;
		end
	end

endmodule

//--- rv_pkg.sv
// shared RV64I constants and types, imported by every core module and the testbench
package rv_pkg;

	// widths with a meaning
	typedef logic [63:0] xlen_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [4:0]  alu_op_t;
	typedef logic [7:0]  byte_sel_t;

	// major opcodes
	localparam logic [6:0] OPC_OP       = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
	localparam logic [6:0] OPC_OP32     = 7'b0111011;
	localparam logic [6:0] OPC_OP_IMM32 = 7'b0011011;
	localparam logic [6:0] OPC_LUI      = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
	localparam logic [6:0] OPC_JAL      = 7'b1101111;
	localparam logic [6:0] OPC_JALR     = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
	localparam logic [6:0] OPC_LOAD     = 7'b0000011;
	localparam logic [6:0] OPC_STORE    = 7'b0100011;

	// funct3 for integer ops
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SR      = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct3 for branches
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// funct3 for loads and stores, low two bits are the size
	localparam logic [2:0] F3_B  = 3'b000;
	localparam logic [2:0] F3_H  = 3'b001;
	localparam logic [2:0] F3_W  = 3'b010;
	localparam logic [2:0] F3_D  = 3'b011;
	localparam logic [2:0] F3_BU = 3'b100;
	localparam logic [2:0] F3_HU = 3'b101;
	localparam logic [2:0] F3_WU = 3'b110;

	// alu operations
	localparam alu_op_t ALU_ZERO = 5'd0;
	localparam alu_op_t ALU_ADD  = 5'd1;
	localparam alu_op_t ALU_SUB  = 5'd2;
	localparam alu_op_t ALU_SLL  = 5'd3;
	localparam alu_op_t ALU_SLT  = 5'd4;
	localparam alu_op_t ALU_SLTU = 5'd5;
	localparam alu_op_t ALU_XOR  = 5'd6;
	localparam alu_op_t ALU_SRL  = 5'd7;
	localparam alu_op_t ALU_SRA  = 5'd8;
	localparam alu_op_t ALU_OR   = 5'd9;
	localparam alu_op_t ALU_AND  = 5'd10;
	localparam alu_op_t ALU_LUI  = 5'd11;
	localparam alu_op_t ALU_ADDW = 5'd12;
	localparam alu_op_t ALU_SUBW = 5'd13;
	localparam alu_op_t ALU_SLLW = 5'd14;
	localparam alu_op_t ALU_SRLW = 5'd15;
	localparam alu_op_t ALU_SRAW = 5'd16;
	localparam alu_op_t ALU_BEQ  = 5'd17;
	localparam alu_op_t ALU_BNE  = 5'd18;
	localparam alu_op_t ALU_BLT  = 5'd19;
	localparam alu_op_t ALU_BGE  = 5'd20;
	localparam alu_op_t ALU_BLTU = 5'd21;
	localparam alu_op_t ALU_BGEU = 5'd22;

	// operand sources
	localparam logic       OP1_REG = 1'b0;
	localparam logic       OP1_PC  = 1'b1;
	localparam logic [1:0] OP2_REG = 2'd0;
	localparam logic [1:0] OP2_IMM = 2'd1;
	localparam logic [1:0] OP2_4   = 2'd2;

	localparam xlen_t RESET_PC = 64'h0;

endpackage

//--- rv_regfile.sv
// integer register file, x1 to x31 with two async reads and one clocked write
`timescale 1ns/1ns

module rv_regfile (
	input  logic              clk,
	input  rv_pkg::reg_addr_t rs1_addr,
	input  rv_pkg::reg_addr_t rs2_addr,
	input  rv_pkg::reg_addr_t rd_addr,
	input  logic              rd_w_ena,
	input  rv_pkg::xlen_t     rd_data,
	output rv_pkg::xlen_t     rs1_data,
	output rv_pkg::xlen_t     rs2_data
);
	import rv_pkg::*;

	// x0 has no storage
	xlen_t regs [1:31];

	always_ff @(posedge clk) begin
		if (rd_w_ena && rd_addr != 5'd0) begin
			regs[rd_addr] <= rd_data;
		end
	end

	assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

//--- rv_result.sv
// memory-side data path, store lane steering, load extension and write-back select
`timescale 1ns/1ns

module rv_result (
	input  rv_pkg::xlen_t     addr,
	input  rv_pkg::xlen_t     rs2_data,
	input  rv_pkg::xlen_t     mem_rdata,
	input  rv_pkg::xlen_t     alu_result,
	input  logic [1:0]        mem_size,
	input  logic              mem_ext_un,
	input  logic              mem_r_ena,
	output rv_pkg::xlen_t     store_data,
	output rv_pkg::byte_sel_t store_sel,
	output rv_pkg::xlen_t     rd_data
);
	import rv_pkg::*;

	logic [5:0] lane_shift;
	byte_sel_t  size_mask;
	xlen_t      load_lane;
	xlen_t      load_val;

	// byte offset within the doubleword, in bits
	assign lane_shift = {addr[2:0], 3'b000};

	always_comb begin
		case (mem_size)
			F3_B[1:0]: size_mask = 8'h01;
			F3_H[1:0]: size_mask = 8'h03;
			F3_W[1:0]: size_mask = 8'h0f;
			default:   size_mask = 8'hff;
		endcase
	end

	// accesses are aligned so the shifted mask never wraps
	assign store_sel  = size_mask << addr[2:0];
	assign store_data = rs2_data << lane_shift;

	// addressed bytes moved down to bit 0
	assign load_lane = mem_rdata >> lane_shift;

	always_comb begin
		case (mem_size)
			F3_B[1:0]: begin
				if (mem_ext_un) begin
					load_val = {56'b0, load_lane[7:0]};
				end else begin
					load_val = {{56{load_lane[7]}}, load_lane[7:0]};
				end
			end
			F3_H[1:0]: begin
				if (mem_ext_un) begin
					load_val = {48'b0, load_lane[15:0]};
				end else begin
					load_val = {{48{load_lane[15]}}, load_lane[15:0]};
				end
			end
			F3_W[1:0]: begin
				if (mem_ext_un) begin
					load_val = {32'b0, load_lane[31:0]};
				end else begin
					load_val = {{32{load_lane[31]}}, load_lane[31:0]};
				end
			end
			default: load_val = load_lane;
		endcase
	end

	assign rd_data = mem_r_ena ? load_val : alu_result;

endmodule

//--- rv_tb.sv
// testbench for rv_core, random program run against an ISA model over a Wishbone memory
`timescale 1ns/1ns

module rv_tb;
	import rv_pkg::*;

	logic      clk;
	logic      rst;
	logic      wb_cyc;
	logic      wb_stb;
	logic      wb_we;
	xlen_t     wb_adr;
	xlen_t     wb_dat_w;
	byte_sel_t wb_sel;
	xlen_t     wb_dat_r;
	logic      wb_ack;

	integer    seed = 32'h115b_3aa4;
	int        errors = 0;
	int        checks = 0;
	int        model_steps = 0;
	logic      model_ready = 1'b0;
	logic      done = 1'b0;
	logic      first_seen = 1'b0;
	logic      pending = 1'b0;
	int        delay = 0;
	time       limit_ns = 0;

	xlen_t     bus_mem [0:1023];
	xlen_t     ref_mem [0:1023];
	inst_t     prog [$];
	logic      q_we [$];
	xlen_t     q_adr [$];
	byte_sel_t q_sel [$];
	xlen_t     q_dat [$];

	rv_tb_clk u_clk (.clk(clk), .rst(rst));

	rv_core DUT (
		.clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack)
	);

	function automatic logic [31:0] rnd();
		rnd = $random(seed);
	endfunction

	// destination never touches x0 or the data base in x1
	function automatic logic [4:0] pick_rd();
		logic [31:0] r;
		r = rnd() % 32'd30;
		pick_rd = 5'(r + 32'd2);
	endfunction

	function automatic inst_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
			input logic [6:0] opc);
		enc_r = {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic inst_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		enc_i = {imm, rs1, f3, rd, opc};
	endfunction

	function automatic inst_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		enc_s = {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic inst_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic inst_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
		enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	function automatic byte_sel_t size_mask(input logic [1:0] sz);
		case (sz)
			2'd0:    size_mask = 8'h01;
			2'd1:    size_mask = 8'h03;
			2'd2:    size_mask = 8'h0f;
			default: size_mask = 8'hff;
		endcase
	endfunction

	task automatic check(input string name, input xlen_t got, input xlen_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	// one random OP, OP-IMM, OP-32 or OP-IMM-32
	task automatic emit_alu();
		logic [31:0] r;
		logic [2:0]  f3;
		logic        alt;
		logic [11:0] imm;
		r   = rnd();
		f3  = r[4:2];
		alt = r[5] && (f3 == F3_ADD_SUB || f3 == F3_SR);
		imm = r[17:6];
		case (r[1:0])
			2'd0: prog.push_back(enc_r({1'b0, alt, 5'b0}, r[22:18], r[27:23], f3,
				pick_rd(), OPC_OP));
			2'd1: begin
				if (f3 == F3_SLL) imm = {6'b0, r[11:6]};
				if (f3 == F3_SR) imm = {1'b0, r[5], 4'b0, r[11:6]};
				prog.push_back(enc_i(imm, r[27:23], f3, pick_rd(), OPC_OP_IMM));
			end
			2'd2: begin
				f3 = (r[3:2] == 2'd0) ? F3_ADD_SUB : (r[3:2] == 2'd1) ? F3_SLL : F3_SR;
				alt = r[5] && f3 != F3_SLL;
				prog.push_back(enc_r({1'b0, alt, 5'b0}, r[22:18], r[27:23], f3,
					pick_rd(), OPC_OP32));
			end
			default: begin
				f3 = (r[3:2] == 2'd0) ? F3_ADD_SUB : (r[3:2] == 2'd1) ? F3_SLL : F3_SR;
				if (f3 == F3_SLL) imm = {7'b0, r[10:6]};
				if (f3 == F3_SR) imm = {1'b0, r[5], 5'b0, r[10:6]};
				prog.push_back(enc_i(imm, r[27:23], f3, pick_rd(), OPC_OP_IMM32));
			end
		endcase
	endtask

	task automatic gen_program();
		logic [31:0] r;
		logic [1:0]  sz;
		logic [2:0]  lane;
		logic [4:0]  ra;
		int          n;
		// x1 holds the data region base 0x1000
		prog.push_back({20'h00001, 5'd1, OPC_LUI});
		for (int i = 2; i < 32; i++) begin
			r = rnd();
			prog.push_back({r[31:12], 5'(i), OPC_LUI});
			prog.push_back(enc_i(r[11:0], 5'(i), F3_ADD_SUB, 5'(i), OPC_OP_IMM));
		end
		for (int k = 0; k < 60; k++) begin
			r    = rnd();
			sz   = r[5:4];
			lane = r[8:6] & ~3'((4'd1 << sz) - 4'd1);
			case (r[3:0] % 4'd10)
				4'd5: prog.push_back(enc_i({3'b0, r[14:9], lane}, 5'd1,
					{r[15] && sz != 2'd3, sz}, pick_rd(), OPC_LOAD));
				4'd6: prog.push_back(enc_s({3'b0, r[14:9], lane}, r[20:16], 5'd1,
					{1'b0, sz}));
				4'd7: begin
					// forward branch over one or two filler ops
					n = r[4] ? 2 : 1;
					ra = (r[23:21] < 3'd2) ? {2'b0, r[23:21]} : {2'b0, r[23:21]} + 5'd2;
					prog.push_back(enc_b(13'(4 * (n + 1)), r[20:16], r[28:24], ra[2:0]));
					repeat (n) emit_alu();
				end
				4'd8: begin
					prog.push_back(enc_j(21'd8, pick_rd()));
					emit_alu();
				end
				4'd9: begin
					ra = pick_rd();
					prog.push_back({20'h0, ra, OPC_AUIPC});
					prog.push_back(enc_i(12'd12, ra, 3'b000, pick_rd(), OPC_JALR));
					emit_alu();
				end
				default: emit_alu();
			endcase
		end
		for (int i = 1; i < 32; i++) begin
			prog.push_back(enc_s(12'(32'h400 + 8 * i), 5'(i), 5'd1, F3_D));
		end
		prog.push_back(enc_j(21'd0, 5'd0));
	endtask

	task automatic expect_access(input logic we, input xlen_t adr, input byte_sel_t sel,
			input xlen_t dat);
		q_we.push_back(we);
		q_adr.push_back(adr);
		q_sel.push_back(sel);
		q_dat.push_back(dat);
	endtask

	// instruction-set model, records every bus access the core should make
	task automatic run_model();
		xlen_t     x [32];
		xlen_t     pc;
		xlen_t     npc;
		xlen_t     a;
		xlen_t     b;
		xlen_t     ii;
		xlen_t     addr;
		xlen_t     val;
		xlen_t     res;
		inst_t     in;
		logic [31:0] w;
		byte_sel_t sel;
		logic      wr;
		logic      cond;
		logic      stop;
		for (int i = 0; i < 32; i++) x[i] = '0;
		pc   = RESET_PC;
		stop = 1'b0;
		while (!stop) begin
			expect_access(1'b0, {pc[63:3], 3'b000}, 8'hff, '0);
			in = pc[2] ? ref_mem[pc[12:3]][63:32] : ref_mem[pc[12:3]][31:0];
			model_steps++;
			a   = x[in[19:15]];
			b   = x[in[24:20]];
			ii  = {{52{in[31]}}, in[31:20]};
			npc = pc + 64'd4;
			res = '0;
			wr  = 1'b1;
			if (in == enc_j(21'd0, 5'd0)) stop = 1'b1;
			case (in[6:0])
				OPC_OP, OPC_OP_IMM: begin
					if (in[6:0] == OPC_OP_IMM) b = ii;
					case (in[14:12])
						F3_ADD_SUB: res = (in[6:0] == OPC_OP && in[30]) ? a - b : a + b;
						F3_SLL:     res = a << b[5:0];
						F3_SLT:     res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
						F3_SLTU:    res = (a < b) ? 64'd1 : 64'd0;
						F3_XOR:     res = a ^ b;
						F3_SR: begin
							if (in[30]) begin
								res = $signed(a) >>> b[5:0];
							end else begin
								res = a >> b[5:0];
							end
						end
						F3_OR:      res = a | b;
						default:    res = a & b;
					endcase
				end
				OPC_OP32, OPC_OP_IMM32: begin
					if (in[6:0] == OPC_OP_IMM32) b = ii;
					case (in[14:12])
						F3_ADD_SUB: w = (in[6:0] == OPC_OP32 && in[30]) ?
							a[31:0] - b[31:0] : a[31:0] + b[31:0];
						F3_SLL:     w = a[31:0] << b[4:0];
						default: begin
							if (in[30]) begin
								w = $signed(a[31:0]) >>> b[4:0];
							end else begin
								w = a[31:0] >> b[4:0];
							end
						end
					endcase
					res = {{32{w[31]}}, w};
				end
				OPC_LUI:   res = {{32{in[31]}}, in[31:12], 12'b0};
				OPC_AUIPC: res = pc + {{32{in[31]}}, in[31:12], 12'b0};
				OPC_JAL: begin
					res = pc + 64'd4;
					npc = pc + {{43{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
				end
				OPC_JALR: begin
					res = pc + 64'd4;
					npc = (a + ii) & ~64'd1;
				end
				OPC_BRANCH: begin
					wr = 1'b0;
					case (in[14:12])
						F3_BEQ:  cond = a == b;
						F3_BNE:  cond = a != b;
						F3_BLT:  cond = $signed(a) < $signed(b);
						F3_BGE:  cond = $signed(a) >= $signed(b);
						F3_BLTU: cond = a < b;
						default: cond = a >= b;
					endcase
					if (cond) npc = pc + {{51{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
				end
				OPC_LOAD: begin
					addr = a + ii;
					sel  = size_mask(in[13:12]) << addr[2:0];
					expect_access(1'b0, {addr[63:3], 3'b000}, sel, '0);
					val = ref_mem[addr[12:3]] >> (8 * addr[2:0]);
					case (in[14:12])
						F3_B:    res = {{56{val[7]}}, val[7:0]};
						F3_H:    res = {{48{val[15]}}, val[15:0]};
						F3_W:    res = {{32{val[31]}}, val[31:0]};
						F3_BU:   res = {56'b0, val[7:0]};
						F3_HU:   res = {48'b0, val[15:0]};
						F3_WU:   res = {32'b0, val[31:0]};
						default: res = val;
					endcase
				end
				OPC_STORE: begin
					wr   = 1'b0;
					addr = a + {{52{in[31]}}, in[31:25], in[11:7]};
					sel  = size_mask(in[13:12]) << addr[2:0];
					val  = b << (8 * addr[2:0]);
					expect_access(1'b1, {addr[63:3], 3'b000}, sel, val);
					for (int k = 0; k < 8; k++) begin
						if (sel[k]) ref_mem[addr[12:3]][8*k +: 8] = val[8*k +: 8];
					end
				end
				default: wr = 1'b0;
			endcase
			if (wr && in[11:7] != 5'd0) x[in[11:7]] = res;
			pc = npc;
		end
	endtask

	// memory slave with 0 to 3 wait cycles, checks each access against the model
	always @(posedge clk) begin
		if (rst) begin
			wb_ack  <= 1'b0;
			pending = 1'b0;
		end else if (wb_ack) begin
			wb_ack <= 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (!pending) begin
				pending = 1'b1;
				delay   = int'({$random(seed)} % 32'd4);
			end
			if (delay == 0) begin
				pending = 1'b0;
				if (!first_seen) check("wb_adr (first fetch)", wb_adr, RESET_PC);
				first_seen = 1'b1;
				if (q_adr.size() == 0) begin
					errors++;
					$display("bus access to %h after the program should have ended", wb_adr);
				end else begin
					check("wb_we", 64'(wb_we), 64'(q_we[0]));
					check("wb_adr", wb_adr, q_adr[0]);
					check("wb_sel", 64'(wb_sel), 64'(q_sel[0]));
					if (q_we[0]) check("wb_dat_w", wb_dat_w, q_dat[0]);
					void'(q_we.pop_front());
					void'(q_adr.pop_front());
					void'(q_sel.pop_front());
					void'(q_dat.pop_front());
					if (q_adr.size() == 0) done = 1'b1;
				end
				wb_dat_r <= bus_mem[wb_adr[12:3]];
				if (wb_we) begin
					for (int k = 0; k < 8; k++) begin
						if (wb_sel[k]) bus_mem[wb_adr[12:3]][8*k +: 8] = wb_dat_w[8*k +: 8];
					end
				end
				wb_ack <= 1'b1;
			end else begin
				delay--;
			end
		end
	end

	// worst case about 14 cycles per instruction, doubled
	initial begin
		wait (model_ready);
		#(limit_ns);
		$display("timeout after %0t, %0d expected bus accesses never happened",
			$time, q_adr.size());
		$display("** FAIL **");
		$finish;
	end

	initial begin
		logic [31:0] iv;
		int          err_start;
		wb_ack   = 1'b0;
		wb_dat_r = '0;
		for (int i = 0; i < 1024; i++) begin
			iv = i;
			bus_mem[i] = {iv * 32'h9e37_79b9, ~(iv * 32'h85eb_ca6b)};
		end
		gen_program();
		foreach (prog[k]) begin
			if (k % 2 == 0) bus_mem[k / 2][31:0] = prog[k];
			else bus_mem[k / 2][63:32] = prog[k];
		end
		for (int i = 0; i < 1024; i++) ref_mem[i] = bus_mem[i];
		run_model();
		limit_ns = time'(model_steps * 28 + 20) * 10;
		model_ready = 1'b1;

		err_start = errors;
		@(negedge clk);
		while (rst) begin
			check("wb_cyc (reset)", 64'(wb_cyc), 64'd0);
			check("wb_stb (reset)", 64'(wb_stb), 64'd0);
			@(negedge clk);
		end
		check("wb_cyc (after reset)", 64'(wb_cyc), 64'd0);
		check("wb_stb (after reset)", 64'(wb_stb), 64'd0);
		$display("test reset: %0d errors", errors - err_start);

		err_start = errors;
		wait (done);
		@(negedge clk);
		$display("test program: %0d instructions, %0d errors", model_steps, errors - err_start);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- rv_tb_clk.sv
// testbench clock and reset source, 10 ns clock with reset held for five cycles
`timescale 1ns/1ns

module rv_tb_clk (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
	end

endmodule
